// File: filelist.f
addr_xlate_pkg.sv
thread_counter.sv
offset_write_port.sv
offset_table.sv
addr_translator.sv
thread_addr_unit.sv
tb_thread_addr_unit.sv

// File: Bender.yml
package:
  name: thread_addr_unit

sources:
  - files:
      - addr_xlate_pkg.sv
      - thread_counter.sv
      - offset_write_port.sv
      - offset_table.sv
      - addr_translator.sv
      - thread_addr_unit.sv
  - target: test
    files:
      - tb_thread_addr_unit.sv

// File: tb_thread_addr_unit.sv
/* testbench for the per-thread address translation stage, with clock, reset,
   watchdog, reference model, check tasks and directed tests */

`timescale 1ns/10ps

module tb_thread_addr_unit
    import addr_xlate_pkg::*;
();

    // defaults of the DUT, which is built with its own parameter values
    localparam int unsigned INITIAL_THREAD      = 0;
    localparam int unsigned OFFSETS_WRITE_DELAY = 2;
    localparam int unsigned OFFSET_ADDR_BASE    = 12'h800;
    localparam int unsigned IO_ADDR_BASE        = 12'hF00;
    localparam int unsigned IO_ADDR_COUNT       = 32;
    localparam int unsigned HIGHMEM_ADDR_BASE   = 12'hC00;
    localparam int unsigned HIGHMEM_ADDR_COUNT  = 256;

    localparam int CLOCK_PERIOD  = 100;
    localparam int ROTATION      = THREAD_COUNT;
    localparam int RANDOM_CYCLES = 200;
    localparam int TEST_CYCLES   = 6 + 2 * ROTATION + 4 * ROTATION + 5 * ROTATION +
                                   2 * ROTATION + 4 * ROTATION + RANDOM_CYCLES + 2;
    localparam int MARGIN_CYCLES = 50;

    logic    clock;
    logic    rst;
    addr_t   addr_in;
    logic    write_en;
    addr_t   write_addr;
    word_t   write_data;
    addr_t   addr_out;
    thread_t current_thread;

    // reference model state
    addr_t   model_offset [THREAD_COUNT];
    int      pend_count   [THREAD_COUNT]; // offset writes not yet in effect, per thread
    thread_t model_thread;
    int      cycle_no;
    addr_t   exp_addr_q [$];
    bit      exp_check_q [$];
    thread_t pend_thread_q [$];
    addr_t   pend_offset_q [$];
    int      pend_cycle_q [$];
    integer  seed;

    thread_addr_unit u_dut (
        .clock          (clock),
        .rst            (rst),
        .addr_in        (addr_in),
        .write_en       (write_en),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .addr_out       (addr_out),
        .current_thread (current_thread)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(CLOCK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        stop_on_failure("the run timed out before all tests finished");
    end

    //////////////////////////////
    // checks

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_thread(input string name, input thread_t got, input thread_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    //////////////////////////////
    // reference model

    function automatic logic passes_through(input addr_t a);
        return (a >= IO_ADDR_BASE && a < IO_ADDR_BASE + IO_ADDR_COUNT) ||
               (a >= HIGHMEM_ADDR_BASE && a < HIGHMEM_ADDR_BASE + HIGHMEM_ADDR_COUNT);
    endfunction

    function automatic logic sets_offset(input logic we, input addr_t wa);
        return we && wa >= OFFSET_ADDR_BASE && wa < OFFSET_ADDR_BASE + THREAD_COUNT;
    endfunction

    function automatic addr_t random_ordinary_addr();
        addr_t a;
        a = addr_t'($random(seed));
        if (passes_through(a)) begin
            a = a ^ 12'h400; // moves either window into translated space
        end
        return a;
    endfunction

    // called mid cycle, when the inputs of this cycle and all outputs are settled
    task automatic model_cycle(input addr_t a, input logic we, input addr_t wa, input word_t wd);
        thread_t t;
        addr_t   exp;
        bit      check;
        check_thread("current_thread", current_thread, model_thread);
        while (pend_cycle_q.size() > 0 && pend_cycle_q[0] <= cycle_no) begin
            t = pend_thread_q.pop_front();
            model_offset[t] = pend_offset_q.pop_front();
            void'(pend_cycle_q.pop_front());
            pend_count[t]--;
        end
        exp = passes_through(a) ? a : addr_t'(a + model_offset[model_thread]);
        exp_addr_q.push_back(exp);
        exp_check_q.push_back(pend_count[model_thread] == 0);
        exp = exp_addr_q.pop_front(); // result of the address two cycles back
        check = exp_check_q.pop_front();
        if (check) begin
            check_addr("addr_out", addr_out, exp);
        end
        if (sets_offset(we, wa)) begin
            pend_thread_q.push_back(model_thread);
            pend_offset_q.push_back(wd[ADDR_WIDTH-1:0]);
            pend_cycle_q.push_back(cycle_no + OFFSETS_WRITE_DELAY + 2);
            pend_count[model_thread]++;
        end
        if (model_thread == thread_t'(THREAD_COUNT - 1)) begin
            model_thread = '0;
        end else begin
            model_thread = model_thread + 1'b1;
        end
        cycle_no++;
    endtask

    task automatic issue_cycle(input addr_t a, input logic we, input addr_t wa, input word_t wd);
        @(posedge clock);
        addr_in    <= a;
        write_en   <= we;
        write_addr <= wa;
        write_data <= wd;
        @(negedge clock);
        model_cycle(a, we, wa, wd);
    endtask

    task automatic reset_dut();
        for (int i = 0; i < THREAD_COUNT; i++) begin
            model_offset[i] = '0;
            pend_count[i]   = 0;
        end
        model_thread = thread_t'(INITIAL_THREAD);
        cycle_no     = 0;
        exp_addr_q.push_back('0); // addr_out holds zero through the two cycles after reset
        exp_check_q.push_back(1'b1);
        exp_addr_q.push_back('0);
        exp_check_q.push_back(1'b1);
        repeat (5) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        model_cycle('0, 1'b0, '0, '0);
    endtask

    //////////////////////////////
    // directed tests

    task automatic test_rotation();
        repeat (2 * ROTATION) issue_cycle('0, 1'b0, '0, '0);
    endtask

    task automatic test_default_offsets();
        repeat (4 * ROTATION) issue_cycle(addr_t'($random(seed)), 1'b0, '0, '0);
    endtask

    task automatic test_per_thread_offsets();
        for (int i = 0; i < ROTATION; i++) begin
            issue_cycle('0, 1'b1, addr_t'(OFFSET_ADDR_BASE + i),
                        {4'hA, addr_t'(12'h123 * (i + 1))}); // upper data bits are dropped
        end
        repeat (2 * ROTATION) issue_cycle('0, 1'b0, '0, '0);
        repeat (2 * ROTATION) issue_cycle(random_ordinary_addr(), 1'b0, '0, '0);
    endtask

    task automatic test_windows();
        addr_t edges [10] = '{12'hF00, 12'hF1F, 12'hC00, 12'hCFF, 12'hF10,
                              12'hC80, 12'hF20, 12'hBFF, 12'hD00, 12'hEFF};
        for (int i = 0; i < 2 * ROTATION; i++) begin
            issue_cycle(edges[i % 10], 1'b0, '0, '0);
        end
    endtask

    task automatic test_ignored_writes();
        addr_t outside [4] = '{12'h808, 12'h7FF, 12'h000, 12'hF00};
        for (int i = 0; i < ROTATION; i++) begin
            issue_cycle(random_ordinary_addr(), 1'b1, outside[i % 4], word_t'($random(seed)));
        end
        for (int i = 0; i < ROTATION; i++) begin
            issue_cycle(random_ordinary_addr(), 1'b0, addr_t'(OFFSET_ADDR_BASE + i),
                        word_t'($random(seed)));
        end
        repeat (2 * ROTATION) issue_cycle(random_ordinary_addr(), 1'b0, '0, '0);
    endtask

    task automatic test_random_mix();
        logic  we;
        addr_t wa;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            we = (($random(seed) & 7) == 0);
            if ($random(seed) & 1) begin
                wa = addr_t'(OFFSET_ADDR_BASE + ($random(seed) & 7));
            end else begin
                wa = addr_t'($random(seed));
            end
            issue_cycle(addr_t'($random(seed)), we, wa, word_t'($random(seed)));
        end
    endtask

    initial begin
        seed       = 63916;
        rst        <= 1'b1;
        addr_in    <= '0;
        write_en   <= 1'b0;
        write_addr <= '0;
        write_data <= '0;
        reset_dut();
        test_rotation();
        test_default_offsets();
        test_per_thread_offsets();
        test_windows();
        test_ignored_writes();
        test_random_mix();
        repeat (2) issue_cycle('0, 1'b0, '0, '0); // drain the last two addresses
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: thread_addr_unit.sv
/* top level of the per-thread address translation stage, connects the
   thread counter, offset write port, offset table and translator */

`timescale 1ns/10ps

module thread_addr_unit
    import addr_xlate_pkg::*;
#(
    parameter int unsigned INITIAL_THREAD      = 0,
    parameter int unsigned OFFSETS_WRITE_DELAY = 2,
    parameter int unsigned OFFSET_ADDR_BASE    = 12'h800,
    parameter int unsigned IO_ADDR_BASE        = 12'hF00,
    parameter int unsigned IO_ADDR_COUNT       = 32,
    parameter int unsigned HIGHMEM_ADDR_BASE   = 12'hC00,
    parameter int unsigned HIGHMEM_ADDR_COUNT  = 256
)
(
    input  logic    clock,
    input  logic    rst,
    input  addr_t   addr_in,
    input  logic    write_en,
    input  addr_t   write_addr,
    input  word_t   write_data,
    output addr_t   addr_out,
    output thread_t current_thread
);

    thread_t next_thread;
    logic    table_wren;
    thread_t table_thread;
    addr_t   table_offset;
    addr_t   offset_value;

    thread_counter #(
        .INITIAL_THREAD (INITIAL_THREAD)
    ) u_thread_counter (
        .clock          (clock),
        .rst            (rst),
        .current_thread (current_thread),
        .next_thread    (next_thread)
    );

    offset_write_port #(
        .OFFSET_ADDR_BASE    (OFFSET_ADDR_BASE),
        .OFFSETS_WRITE_DELAY (OFFSETS_WRITE_DELAY)
    ) u_offset_write_port (
        .clock          (clock),
        .rst            (rst),
        .write_en       (write_en),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .current_thread (current_thread),
        .table_wren     (table_wren),
        .table_thread   (table_thread),
        .table_offset   (table_offset)
    );

    // read one slot ahead so the offset meets its thread's address
    offset_table u_offset_table (
        .clock        (clock),
        .wren         (table_wren),
        .write_thread (table_thread),
        .write_offset (table_offset),
        .read_thread  (next_thread),
        .offset_value (offset_value)
    );

    addr_translator #(
        .IO_ADDR_BASE       (IO_ADDR_BASE),
        .IO_ADDR_COUNT      (IO_ADDR_COUNT),
        .HIGHMEM_ADDR_BASE  (HIGHMEM_ADDR_BASE),
        .HIGHMEM_ADDR_COUNT (HIGHMEM_ADDR_COUNT)
    ) u_addr_translator (
        .clock        (clock),
        .rst          (rst),
        .addr_in      (addr_in),
        .offset_value (offset_value),
        .addr_out     (addr_out)
    );

endmodule

// File: addr_translator.sv
/* address translator, decodes the I/O and high-memory windows, adds the
   thread offset and registers the raw or translated address */

`timescale 1ns/10ps

module addr_translator
    import addr_xlate_pkg::*;
#(
    parameter int unsigned IO_ADDR_BASE       = 12'hF00,
    parameter int unsigned IO_ADDR_COUNT      = 32,
    parameter int unsigned HIGHMEM_ADDR_BASE  = 12'hC00,
    parameter int unsigned HIGHMEM_ADDR_COUNT = 256
)
(
    input  logic  clock,
    input  logic  rst,
    input  addr_t addr_in,
    input  addr_t offset_value,
    output addr_t addr_out
);

    //////////////////////////////
    // window decode

    logic in_io;
    logic in_highmem;

    always_comb begin
        in_io      = (32'(addr_in) >= IO_ADDR_BASE) &&
                     (32'(addr_in) < IO_ADDR_BASE + IO_ADDR_COUNT);
        in_highmem = (32'(addr_in) >= HIGHMEM_ADDR_BASE) &&
                     (32'(addr_in) < HIGHMEM_ADDR_BASE + HIGHMEM_ADDR_COUNT);
    end

    //////////////////////////////
    // stage 1

    addr_t raw_addr;
    addr_t offset_addr;
    logic  use_raw_addr;

    always_ff @(posedge clock) begin
        raw_addr    <= addr_in;
        offset_addr <= addr_in + offset_value; // wraps around the top of the address space
    end

    // shared devices and high memory are the same for all threads
    always_ff @(posedge clock) begin
        if (rst) begin
            use_raw_addr <= 1'b0;
        end else begin
            use_raw_addr <= in_io || in_highmem;
        end
    end

    //////////////////////////////
    // stage 2

    always_ff @(posedge clock) begin
        if (rst) begin
            addr_out <= '0;
        end else if (use_raw_addr) begin
            addr_out <= raw_addr;
        end else begin
            addr_out <= offset_addr;
        end
    end

    //////////////////////////////
    // checks

    // the memory map keeps the two windows apart
    a_windows_disjoint : assert property (
        @(posedge clock) disable iff (rst)
        !(in_io && in_highmem)
    ) else $error("address 0x%h falls in both the I/O and high-memory windows", addr_in);

endmodule

// File: offset_table.sv
/* per-thread offset memory, one write port and one registered read port */

`timescale 1ns/10ps

module offset_table
    import addr_xlate_pkg::*;
(
    input  logic    clock,
    input  logic    wren,
    input  thread_t write_thread,
    input  addr_t   write_offset,
    input  thread_t read_thread,
    output addr_t   offset_value
);

    addr_t mem [THREAD_COUNT];

    // threads that never wrote an offset see their addresses untouched
    initial begin
        for (int i = 0; i < THREAD_COUNT; i++) begin
            mem[i] = '0;
        end
    end

    //////////////////////////////
    // write side

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_thread] <= write_offset;
        end
    end

    //////////////////////////////
    // read side

    // read_thread runs one slot ahead, so the value lands in its own slot
    // a read on the same edge as a write returns the old offset
    always_ff @(posedge clock) begin
        offset_value <= mem[read_thread];
    end

endmodule

// File: offset_write_port.sv
/* offset write capture, decodes the offset window, tags each hit with the
   issuing thread and delays it to line up with the data memory writes */

`timescale 1ns/10ps

module offset_write_port
    import addr_xlate_pkg::*;
#(
    parameter int unsigned OFFSET_ADDR_BASE    = 12'h800,
    parameter int unsigned OFFSETS_WRITE_DELAY = 2
)
(
    input  logic    clock,
    input  logic    rst,
    input  logic    write_en,
    input  addr_t   write_addr,
    input  word_t   write_data,
    input  thread_t current_thread,
    output logic    table_wren,
    output thread_t table_thread,
    output addr_t   table_offset
);

    //////////////////////////////
    // window decode

    logic in_window;
    logic write_hit;

    // any of the THREAD_COUNT words in the window sets the offset of the issuing thread
    always_comb begin
        in_window = (32'(write_addr) >= OFFSET_ADDR_BASE) &&
                    (32'(write_addr) < OFFSET_ADDR_BASE + THREAD_COUNT);
        write_hit = write_en && in_window;
    end

    //////////////////////////////
    // delay line

    logic    wren_pipe   [OFFSETS_WRITE_DELAY];
    thread_t thread_pipe [OFFSETS_WRITE_DELAY];
    addr_t   offset_pipe [OFFSETS_WRITE_DELAY];

    // only the enables need a known value after reset
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < OFFSETS_WRITE_DELAY; i++) begin
                wren_pipe[i] <= 1'b0;
            end
        end else begin
            wren_pipe[0] <= write_hit;
            for (int i = 1; i < OFFSETS_WRITE_DELAY; i++) begin
                wren_pipe[i] <= wren_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        thread_pipe[0] <= current_thread;            // thread that owned the slot
        offset_pipe[0] <= write_data[ADDR_WIDTH-1:0]; // an offset spans the address space
        for (int i = 1; i < OFFSETS_WRITE_DELAY; i++) begin
            thread_pipe[i] <= thread_pipe[i-1];
            offset_pipe[i] <= offset_pipe[i-1];
        end
    end

    assign table_wren   = wren_pipe[OFFSETS_WRITE_DELAY-1];
    assign table_thread = thread_pipe[OFFSETS_WRITE_DELAY-1];
    assign table_offset = offset_pipe[OFFSETS_WRITE_DELAY-1];

    //////////////////////////////
    // checks

    // a table write must come from a strobe exactly one delay line length back
    a_wren_has_strobe : assert property (
        @(posedge clock) disable iff (rst)
        table_wren |-> $past(write_en, OFFSETS_WRITE_DELAY)
    ) else $error("table write without a matching write strobe");

endmodule

// File: thread_counter.sv
/* barrel issue slot counter, gives the current thread and the one after it */

`timescale 1ns/10ps

module thread_counter
    import addr_xlate_pkg::*;
#(
    parameter int unsigned INITIAL_THREAD = 0
)
(
    input  logic    clock,
    input  logic    rst,
    output thread_t current_thread,
    output thread_t next_thread
);

    localparam thread_t LAST_THREAD = thread_t'(THREAD_COUNT - 1);

    // wrap explicitly so a thread count that is not a power of two still works
    always_comb begin
        if (current_thread == LAST_THREAD) begin
            next_thread = '0;
        end else begin
            next_thread = current_thread + thread_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            current_thread <= thread_t'(INITIAL_THREAD);
        end else begin
            current_thread <= next_thread; // one slot per clock
        end
    end

    // the offset table is indexed by this counter and has no entries past the last thread
    a_thread_in_range : assert property (
        @(posedge clock) disable iff (rst)
        32'(current_thread) < THREAD_COUNT
    ) else $error("current_thread left the thread range");

endmodule

// File: addr_xlate_pkg.sv
/* shared widths, thread count and word types for the per-thread address
   translation stage */

package addr_xlate_pkg;

    //////////////////////////////
    // widths

    // data address width, the whole data space is 4096 words
    localparam int ADDR_WIDTH = 12;

    // width of a word on the data write path
    localparam int WORD_WIDTH = 16;

    //////////////////////////////
    // barrel threads

    localparam int THREAD_COUNT = 8; // threads issue in strict rotation
    localparam int THREAD_WIDTH = 3; // enough bits to number every thread

    //////////////////////////////
    // word types

    // a data address as issued by a thread or sent on to memory
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // a written data word, an offset is its low ADDR_WIDTH bits
    typedef logic [WORD_WIDTH-1:0] word_t;

    // the number of a hardware thread
    typedef logic [THREAD_WIDTH-1:0] thread_t;

endpackage
